// File: files.f
design/exu_cfg_pkg.sv
design/exu_isa_pkg.sv
design/exu_queue.sv
design/exu_ialu.sv
design/exu_operand_wb.sv
design/exu_pc_ctrl.sv
design/exu_top.sv
sim/exu_tb.sv

// File: Bender.yml
package:
  name: exu_stage

sources:
  - design/exu_cfg_pkg.sv
  - design/exu_isa_pkg.sv
  - design/exu_queue.sv
  - design/exu_ialu.sv
  - design/exu_operand_wb.sv
  - design/exu_pc_ctrl.sv
  - design/exu_top.sv
  - target: simulation
    files:
      - sim/exu_tb.sv

// File: sim/exu_tb.sv
// Directed testbench for the execute stage
// Clock, reset, register-file model, command tasks and typed checks
`timescale 1ns/10ps
`default_nettype none

module exu_tb;
    import exu_cfg_pkg::*;
    import exu_isa_pkg::*;

    localparam xlen_t       rst_vec  = 32'h0000_1000;
    localparam xlen_t       trap_vec = 32'h0000_0400;
    localparam exc_report_t no_exc   = '0;

    logic         clk;
    logic         rst_n;
    logic         cmd_req;
    exu_cmd_t     cmd;
    rf_addr_t     rs1_addr;
    rf_addr_t     rs2_addr;
    xlen_t        rs1_data;
    xlen_t        rs2_data;
    logic         rf_we;
    rf_addr_t     rf_waddr;
    xlen_t        rf_wdata;
    xlen_t        curr_pc;
    logic         new_pc_req;
    xlen_t        new_pc;
    logic         init_pc;
    logic         instret;
    exc_report_t  exc;
    xlen_t        rf [0:31];   // Register-file model
    integer       seed;
    xlen_t        exp_pc;      // PC the DUT should hold

    exu_top #(
        .rst_vector(rst_vec),
        .trap_vector(trap_vec)
    ) dut_i (
        .clk(clk), .rst_n(rst_n), .cmd_req(cmd_req), .cmd(cmd),
        .rs1_addr(rs1_addr), .rs1_data(rs1_data), .rs2_addr(rs2_addr), .rs2_data(rs2_data),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata), .curr_pc(curr_pc),
        .new_pc_req(new_pc_req), .new_pc(new_pc), .init_pc(init_pc),
        .instret(instret), .exc(exc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    assign rs1_data = rf[rs1_addr];   // Combinational read ports
    assign rs2_data = rf[rs2_addr];

    always @(posedge clk) begin
        if (rf_we) begin
            rf[rf_waddr] <= rf_wdata;
        end
    end

    //----------------------------------------------------------------------
    // Checks and reference rules
    //----------------------------------------------------------------------
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_word(input string what, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_reg(input string what, input rf_addr_t got, input rf_addr_t exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR at %0t ns: %s is x%0d, expected x%0d", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_exc(input exc_report_t got, input exc_report_t exp);
        if (got.exc_req !== exp.exc_req || (exp.exc_req &&
            (got.exc_code !== exp.exc_code || got.trap_val !== exp.trap_val))) begin
            fail_run($sformatf("ERROR at %0t ns: exc is %b/%0d/%h, expected %b/%0d/%h", $time,
                got.exc_req, got.exc_code, got.trap_val, exp.exc_req, exp.exc_code, exp.trap_val));
        end
    endtask

    function automatic xlen_t alu_model(input ialu_cmd_e op, input xlen_t a, input xlen_t b);
        case (op)
            ialu_cmd_add  : return a + b;
            ialu_cmd_sub  : return a - b;
            ialu_cmd_and  : return a & b;
            ialu_cmd_or   : return a | b;
            ialu_cmd_xor  : return a ^ b;
            ialu_cmd_sll  : return a << b[4:0];   // Shift amount is 5 bits
            ialu_cmd_srl  : return a >> b[4:0];
            ialu_cmd_sra  : return xlen_t'($signed(a) >>> b[4:0]);
            ialu_cmd_slt  : return {31'd0, $signed(a) < $signed(b)};
            ialu_cmd_sltu : return {31'd0, a < b};
            default       : return '0;
        endcase
    endfunction

    function automatic logic branch_model(input ialu_cmd_e op, input xlen_t a, input xlen_t b);
        case (op)
            ialu_cmd_eq  : return a == b;
            ialu_cmd_ne  : return a != b;
            ialu_cmd_lt  : return $signed(a) < $signed(b);
            ialu_cmd_ge  : return $signed(a) >= $signed(b);
            ialu_cmd_ltu : return a < b;
            default      : return a >= b;   // geu
        endcase
    endfunction

    function automatic rf_addr_t pick_reg();
        rf_addr_t r;
        r = rf_addr_t'($random(seed));
        if (r == '0) r = 5'd1;   // Keep x0 out of the way
        return r;
    endfunction

    //----------------------------------------------------------------------
    // Stimulus helpers
    //----------------------------------------------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic send_cmd(input exu_cmd_t c);
        cmd     = c;
        cmd_req = 1'b1;
        next_cycle();
        cmd_req = 1'b0;
    endtask

    task automatic wait_retire();
        int n;
        n = 0;
        @(negedge clk);
        while (instret !== 1'b1) begin
            n++;
            if (n >= 20) fail_run("Timeout: the command did not retire within 20 cycles");
            @(negedge clk);
        end
    endtask

    // Checks one retiring command, then steps past its PC update
    task automatic expect_retire(input logic we, input rf_addr_t rd, input xlen_t data,
                                 input logic redir, input xlen_t target, input exc_report_t ex);
        check_word("curr_pc", curr_pc, exp_pc);
        check_flag("rf_we", rf_we, we);
        if (we) begin
            check_reg("rf_waddr", rf_waddr, rd);
            check_word("rf_wdata", rf_wdata, data);
        end
        check_flag("new_pc_req", new_pc_req, redir);
        if (redir) check_word("new_pc", new_pc, target);
        check_exc(exc, ex);
        exp_pc = redir ? target : exp_pc + 32'd4;
        next_cycle();
    endtask

    //----------------------------------------------------------------------
    // Directed tests
    //----------------------------------------------------------------------
    task automatic reset_and_init_pc();
        int n;
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        n     = 0;
        @(negedge clk);
        while (init_pc !== 1'b1) begin
            check_flag("new_pc_req", new_pc_req, 1'b0);
            check_flag("rf_we", rf_we, 1'b0);
            n++;
            if (n >= 20) fail_run("Timeout: init_pc was never raised after reset");
            @(negedge clk);
        end
        check_word("init_pc cycle", xlen_t'(n), 32'd3);   // Third cycle after release
        check_flag("new_pc_req", new_pc_req, 1'b1);
        check_word("new_pc", new_pc, rst_vec);
        check_word("curr_pc", curr_pc, rst_vec);
        @(negedge clk);
        check_flag("init_pc", init_pc, 1'b0);
        check_flag("new_pc_req", new_pc_req, 1'b0);
        next_cycle();
        exp_pc = rst_vec;
    endtask

    task automatic alu_ops();
        exu_cmd_t c;
        xlen_t    b;
        for (int form = 0; form < 2; form++) begin
            for (int k = 1; k <= 10; k++) begin
                c           = '0;
                c.ialu_op   = ialu_op_e'(form);
                c.ialu_cmd  = ialu_cmd_e'(k);
                c.rd_wb_sel = rd_wb_ialu;
                c.rs1_addr  = pick_reg();
                c.rs2_addr  = pick_reg();
                c.rd_addr   = pick_reg();
                c.imm       = $random(seed);
                send_cmd(c);
                wait_retire();
                b = (form == 1) ? c.imm : rf[c.rs2_addr];
                expect_retire(1'b1, c.rd_addr, alu_model(c.ialu_cmd, rf[c.rs1_addr], b),
                              1'b0, '0, no_exc);
            end
        end
    endtask

    task automatic upper_imm_ops();
        exu_cmd_t c;
        c           = '0;
        c.rd_wb_sel = rd_wb_imm;   // lui
        c.rd_addr   = pick_reg();
        c.imm       = $random(seed) & 32'hFFFF_F000;
        send_cmd(c);
        wait_retire();
        expect_retire(1'b1, c.rd_addr, c.imm, 1'b0, '0, no_exc);
        c.rd_wb_sel = rd_wb_sum2;  // auipc
        c.sum2_op   = sum2_op_pc_imm;
        c.imm       = 32'h0001_2000;
        send_cmd(c);
        wait_retire();
        expect_retire(1'b1, c.rd_addr, exp_pc + c.imm, 1'b0, '0, no_exc);
    endtask

    task automatic jumps_and_flush();
        exu_cmd_t jmp;
        exu_cmd_t other;
        xlen_t    tgt;
        for (int form = 0; form < 2; form++) begin
            jmp           = '0;
            jmp.jump_req  = 1'b1;
            jmp.rd_wb_sel = rd_wb_inc_pc;
            jmp.rd_addr   = pick_reg();
            jmp.imm       = 32'h0000_0041;   // Odd offset, bit 0 dropped
            if (form == 1) begin
                jmp.sum2_op  = sum2_op_reg_imm;
                jmp.rs1_addr = pick_reg();
                jmp.imm      = 32'h0000_0301 - rf[jmp.rs1_addr];
            end
            other           = '0;
            other.ialu_cmd  = ialu_cmd_add;
            other.rd_wb_sel = rd_wb_ialu;
            other.rd_addr   = pick_reg();
            send_cmd(jmp);
            cmd     = other;                 // Wrong-path command behind the jump
            cmd_req = 1'b1;
            wait_retire();
            tgt    = ((form == 1) ? rf[jmp.rs1_addr] : exp_pc) + jmp.imm;
            tgt[0] = 1'b0;
            expect_retire(1'b1, jmp.rd_addr, exp_pc + 32'd4, 1'b1, tgt, no_exc);
            cmd_req = 1'b0;
            @(negedge clk);
            check_flag("instret after flush", instret, 1'b0);
            check_flag("rf_we after flush", rf_we, 1'b0);
            next_cycle();
        end
    endtask

    task automatic branches();
        exu_cmd_t c;
        logic     taken;
        for (int k = 11; k <= 16; k++) begin
            for (int same = 0; same < 2; same++) begin
                c            = '0;
                c.ialu_cmd   = ialu_cmd_e'(k);
                c.branch_req = 1'b1;
                c.rs1_addr   = pick_reg();
                c.rs2_addr   = (same == 1) ? c.rs1_addr : pick_reg();
                c.imm        = (same == 1) ? 32'hFFFF_FFF0 : 32'h0000_0024;
                send_cmd(c);
                wait_retire();
                taken = branch_model(c.ialu_cmd, rf[c.rs1_addr], rf[c.rs2_addr]);
                expect_retire(1'b0, '0, '0, taken, exp_pc + c.imm, no_exc);
            end
        end
    endtask

    task automatic exceptions();
        exu_cmd_t    c;
        exc_report_t ex;
        c           = '0;
        c.exc_req   = 1'b1;
        c.exc_code  = exc_code_illegal_instr;
        c.ialu_cmd  = ialu_cmd_add;
        c.rd_wb_sel = rd_wb_ialu;            // Write must be blocked
        c.rd_addr   = pick_reg();
        c.imm       = $random(seed);         // Raw instruction word
        ex          = '0;
        ex.exc_req  = 1'b1;
        send_cmd(c);
        wait_retire();
        ex.exc_code = exc_code_illegal_instr;
        ex.trap_val = c.imm;
        expect_retire(1'b0, '0, '0, 1'b1, trap_vec, ex);
        c.exc_code = exc_code_instr_access_fault;
        send_cmd(c);
        wait_retire();
        ex.exc_code = exc_code_instr_access_fault;
        ex.trap_val = exp_pc;
        expect_retire(1'b0, '0, '0, 1'b1, trap_vec, ex);
        c           = '0;
        c.jump_req  = 1'b1;
        c.rd_wb_sel = rd_wb_inc_pc;
        c.rd_addr   = pick_reg();
        c.imm       = 32'h0000_0013;         // Target lands on bit 1
        send_cmd(c);
        wait_retire();
        ex.exc_code = exc_code_instr_misalign;
        ex.trap_val = (exp_pc + c.imm) & 32'hFFFF_FFFE;
        expect_retire(1'b0, '0, '0, 1'b1, trap_vec, ex);
    endtask

    initial begin
        seed    = 55217;
        rst_n   = 1'b0;
        cmd_req = 1'b0;
        cmd     = '0;
        exp_pc  = rst_vec;
        for (int i = 0; i < 32; i++) begin
            rf[i] = $random(seed);
        end
        rf[0] = '0;
        reset_and_init_pc();
        alu_ops();
        upper_imm_ops();
        jumps_and_flush();
        branches();
        exceptions();
        @(negedge clk);
        check_word("final curr_pc", curr_pc, exp_pc);
        $display("Test passed");
        $finish;
    end

endmodule : exu_tb

`default_nettype wire

// File: design/exu_top.sv
// Execute stage top level
// Stage register, integer ALU, operand/write-back unit and PC control
`timescale 1ns/10ps
`default_nettype none

module exu_top #(
    parameter exu_cfg_pkg::xlen_t rst_vector  = exu_cfg_pkg::default_rst_vector,
    parameter exu_cfg_pkg::xlen_t trap_vector = exu_cfg_pkg::default_trap_vector
) (
    input  logic                      clk,
    input  logic                      rst_n,
    // Decode stage
    input  logic                      cmd_req,
    input  exu_isa_pkg::exu_cmd_t     cmd,
    // Register file
    output exu_cfg_pkg::rf_addr_t     rs1_addr,
    input  exu_cfg_pkg::xlen_t        rs1_data,
    output exu_cfg_pkg::rf_addr_t     rs2_addr,
    input  exu_cfg_pkg::xlen_t        rs2_data,
    output logic                      rf_we,
    output exu_cfg_pkg::rf_addr_t     rf_waddr,
    output exu_cfg_pkg::xlen_t        rf_wdata,
    // PC and retirement
    output exu_cfg_pkg::xlen_t        curr_pc,
    output logic                      new_pc_req,
    output exu_cfg_pkg::xlen_t        new_pc,
    output logic                      init_pc,
    output logic                      instret,
    output exu_isa_pkg::exc_report_t  exc
);
    import exu_cfg_pkg::*;
    import exu_isa_pkg::*;

    logic      q_vd;
    exu_cmd_t  q_cmd;
    xlen_t     op1;
    xlen_t     op2;
    xlen_t     sum2_op1;
    xlen_t     sum2_op2;
    xlen_t     ialu_res;
    logic      ialu_cmp;
    xlen_t     sum2_res;
    xlen_t     inc_pc;

    exu_queue i_queue (
        .clk(clk), .rst_n(rst_n), .cmd_req(cmd_req), .cmd(cmd),
        .flush(new_pc_req), .q_vd(q_vd), .q_cmd(q_cmd)
    );

    exu_ialu i_ialu (
        .op1(op1), .op2(op2), .sum2_op1(sum2_op1), .sum2_op2(sum2_op2),
        .ialu_cmd(q_cmd.ialu_cmd), .ialu_res(ialu_res), .ialu_cmp(ialu_cmp),
        .sum2_res(sum2_res)
    );

    exu_operand_wb i_operand_wb (
        .q_vd(q_vd), .q_cmd(q_cmd), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .curr_pc(curr_pc), .inc_pc(inc_pc), .ialu_res(ialu_res), .sum2_res(sum2_res),
        .exc_req(exc.exc_req), .op1(op1), .op2(op2), .sum2_op1(sum2_op1),
        .sum2_op2(sum2_op2), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata)
    );

    exu_pc_ctrl #(
        .rst_vector(rst_vector),
        .trap_vector(trap_vector)
    ) i_pc_ctrl (
        .clk(clk), .rst_n(rst_n), .q_vd(q_vd), .q_cmd(q_cmd), .ialu_cmp(ialu_cmp),
        .sum2_res(sum2_res), .curr_pc(curr_pc), .inc_pc(inc_pc),
        .new_pc_req(new_pc_req), .new_pc(new_pc), .init_pc(init_pc),
        .instret(instret), .exc(exc)
    );

endmodule : exu_top

`default_nettype wire

// File: design/exu_pc_ctrl.sv
// PC control of the execute stage
// Reset PC sequencer, current PC register, redirect decision,
// exception code and trap value
`timescale 1ns/10ps
`default_nettype none

module exu_pc_ctrl #(
    parameter exu_cfg_pkg::xlen_t rst_vector  = exu_cfg_pkg::default_rst_vector,
    parameter exu_cfg_pkg::xlen_t trap_vector = exu_cfg_pkg::default_trap_vector
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      q_vd,
    input  exu_isa_pkg::exu_cmd_t     q_cmd,
    input  logic                      ialu_cmp,   // Branch taken
    input  exu_cfg_pkg::xlen_t        sum2_res,   // Raw jump/branch target
    output exu_cfg_pkg::xlen_t        curr_pc,
    output exu_cfg_pkg::xlen_t        inc_pc,
    output logic                      new_pc_req,
    output exu_cfg_pkg::xlen_t        new_pc,
    output logic                      init_pc,
    output logic                      instret,
    output exu_isa_pkg::exc_report_t  exc
);
    import exu_cfg_pkg::*;
    import exu_isa_pkg::*;

    logic [3:0]  init_seq;
    logic        jb_taken;
    logic        jb_misalign;
    logic        exc_req;
    exc_code_e   exc_code;
    xlen_t       trap_val;
    xlen_t       tgt_pc;

    //----------------------------------------------------------------------
    // Reset exit
    //----------------------------------------------------------------------
    // Ones shift in after reset; init_pc marks the 0111 state only
    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            init_seq <= '0;
        end else if (~&init_seq) begin
            init_seq <= {init_seq[2:0], 1'b1};
        end
    end

    assign init_pc = ~init_seq[3] & init_seq[2];

    //----------------------------------------------------------------------
    // Jumps, branches and exceptions
    //----------------------------------------------------------------------
    assign tgt_pc      = sum2_res & jump_mask;
    assign jb_taken    = q_vd & (q_cmd.jump_req | (q_cmd.branch_req & ialu_cmp));
    assign jb_misalign = jb_taken & (|tgt_pc[1:0]);   // No compressed support

    assign exc_req  = q_vd & (q_cmd.exc_req | jb_misalign);
    assign exc_code = q_cmd.exc_req ? q_cmd.exc_code :
                      jb_misalign   ? exc_code_instr_misalign : exc_code_ecall_m;

    always_comb begin
        case (exc_code)
            exc_code_instr_misalign     : trap_val = tgt_pc;
            exc_code_instr_access_fault : trap_val = curr_pc;
            exc_code_illegal_instr      : trap_val = q_cmd.imm;   // Instruction word
            default                     : trap_val = '0;
        endcase
    end

    assign exc = {exc_req, exc_code, trap_val};

    //----------------------------------------------------------------------
    // PC update
    //----------------------------------------------------------------------
    assign new_pc_req = init_pc | exc_req | jb_taken;
    assign new_pc     = init_pc ? rst_vector  :
                        exc_req ? trap_vector : tgt_pc;
    assign inc_pc     = curr_pc + xlen_t'(4);
    assign instret    = q_vd;   // Single-cycle stage retires at once

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            curr_pc <= rst_vector;
        end else if (instret) begin
            curr_pc <= new_pc_req ? new_pc : inc_pc;
        end
    end

endmodule : exu_pc_ctrl

`default_nettype wire

// File: design/exu_operand_wb.sv
// Operand fetch and register write-back for the execute stage
// Register file read addresses, ALU/adder operand muxes, write port
`timescale 1ns/10ps
`default_nettype none

module exu_operand_wb (
    input  logic                   q_vd,
    input  exu_isa_pkg::exu_cmd_t  q_cmd,
    input  exu_cfg_pkg::xlen_t     rs1_data,
    input  exu_cfg_pkg::xlen_t     rs2_data,
    input  exu_cfg_pkg::xlen_t     curr_pc,
    input  exu_cfg_pkg::xlen_t     inc_pc,
    input  exu_cfg_pkg::xlen_t     ialu_res,
    input  exu_cfg_pkg::xlen_t     sum2_res,
    input  logic                   exc_req,    // Blocks write-back
    output exu_cfg_pkg::xlen_t     op1,
    output exu_cfg_pkg::xlen_t     op2,
    output exu_cfg_pkg::xlen_t     sum2_op1,
    output exu_cfg_pkg::xlen_t     sum2_op2,
    output exu_cfg_pkg::rf_addr_t  rs1_addr,
    output exu_cfg_pkg::rf_addr_t  rs2_addr,
    output logic                   rf_we,
    output exu_cfg_pkg::rf_addr_t  rf_waddr,
    output exu_cfg_pkg::xlen_t     rf_wdata
);
    import exu_isa_pkg::*;

    //----------------------------------------------------------------------
    // Operand fetch
    //----------------------------------------------------------------------
    assign rs1_addr = q_cmd.rs1_addr;
    assign rs2_addr = q_cmd.rs2_addr;

    assign op1      = rs1_data;
    assign op2      = (q_cmd.ialu_op == ialu_op_reg_imm) ? q_cmd.imm : rs2_data;
    assign sum2_op1 = (q_cmd.sum2_op == sum2_op_reg_imm) ? rs1_data : curr_pc;  // jalr vs jal
    assign sum2_op2 = q_cmd.imm;

    //----------------------------------------------------------------------
    // Write-back
    //----------------------------------------------------------------------
    assign rf_we    = q_vd & (q_cmd.rd_wb_sel != rd_wb_none) & ~exc_req;
    assign rf_waddr = q_cmd.rd_addr;

    always_comb begin
        case (q_cmd.rd_wb_sel)
            rd_wb_sum2   : rf_wdata = sum2_res;
            rd_wb_imm    : rf_wdata = q_cmd.imm;
            rd_wb_inc_pc : rf_wdata = inc_pc;
            default      : rf_wdata = ialu_res;
        endcase
    end

endmodule : exu_operand_wb

`default_nettype wire

// File: design/exu_ialu.sv
// Integer ALU of the execute stage
// Arithmetic, logic, shifts, compare flag and the address adder
`timescale 1ns/10ps
`default_nettype none

module exu_ialu (
    input  exu_cfg_pkg::xlen_t      op1,
    input  exu_cfg_pkg::xlen_t      op2,
    input  exu_cfg_pkg::xlen_t      sum2_op1,
    input  exu_cfg_pkg::xlen_t      sum2_op2,
    input  exu_isa_pkg::ialu_cmd_e  ialu_cmd,
    output exu_cfg_pkg::xlen_t      ialu_res,
    output logic                    ialu_cmp,   // Comparison result
    output exu_cfg_pkg::xlen_t      sum2_res    // Jump, branch and auipc address
);
    import exu_cfg_pkg::*;
    import exu_isa_pkg::*;

    localparam int unsigned shamt_w = $clog2(xlen);

    logic [xlen:0]       sub_res;   // Top bit is the borrow
    logic                lt_u;
    logic                lt_s;
    logic                cmp_eq;
    logic [shamt_w-1:0]  shamt;

    // One subtractor serves sub and all compares
    assign sub_res = {1'b0, op1} - {1'b0, op2};
    assign lt_u    = sub_res[xlen];
    assign lt_s    = (op1[xlen-1] != op2[xlen-1]) ? op1[xlen-1] : sub_res[xlen-1];
    assign cmp_eq  = (op1 == op2);
    assign shamt   = op2[shamt_w-1:0];

    always_comb begin
        ialu_res = '0;
        ialu_cmp = 1'b0;
        case (ialu_cmd)
            ialu_cmd_add  : ialu_res = op1 + op2;
            ialu_cmd_sub  : ialu_res = sub_res[xlen-1:0];
            ialu_cmd_and  : ialu_res = op1 & op2;
            ialu_cmd_or   : ialu_res = op1 | op2;
            ialu_cmd_xor  : ialu_res = op1 ^ op2;
            ialu_cmd_sll  : ialu_res = op1 << shamt;
            ialu_cmd_srl  : ialu_res = op1 >> shamt;
            ialu_cmd_sra  : ialu_res = $signed(op1) >>> shamt;
            ialu_cmd_slt  : begin
                ialu_cmp = lt_s;
                ialu_res = xlen_t'(lt_s);
            end
            ialu_cmd_sltu : begin
                ialu_cmp = lt_u;
                ialu_res = xlen_t'(lt_u);
            end
            ialu_cmd_eq   : ialu_cmp = cmp_eq;
            ialu_cmd_ne   : ialu_cmp = ~cmp_eq;
            ialu_cmd_lt   : ialu_cmp = lt_s;
            ialu_cmd_ge   : ialu_cmp = ~lt_s;
            ialu_cmd_ltu  : ialu_cmp = lt_u;
            ialu_cmd_geu  : ialu_cmp = ~lt_u;
            default       : ialu_res = '0;   // ialu_cmd_none
        endcase
    end

    assign sum2_res = sum2_op1 + sum2_op2;

endmodule : exu_ialu

`default_nettype wire

// File: design/exu_queue.sv
// One-entry command stage register between decode and execute
// Valid bit with flush on redirect, unreset payload
`timescale 1ns/10ps
`default_nettype none

module exu_queue (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cmd_req,    // New command from decode
    input  exu_isa_pkg::exu_cmd_t  cmd,
    input  logic                   flush,      // Redirect in this cycle
    output logic                   q_vd,
    output exu_isa_pkg::exu_cmd_t  q_cmd
);

    //----------------------------------------------------------------------
    // Valid bit
    //----------------------------------------------------------------------
    // The stage never stalls, so the bit reloads on every edge.
    // A command accepted together with a redirect belongs to the
    // wrong path and is dropped here.
    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            q_vd <= 1'b0;
        end else begin
            q_vd <= cmd_req & ~flush;
        end
    end

    //----------------------------------------------------------------------
    // Command payload
    //----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (cmd_req) begin
            q_cmd <= cmd;          // Loads even while the old entry retires
        end
    end

endmodule : exu_queue

`default_nettype wire

// File: design/exu_isa_pkg.sv
// ISA-side encodings seen by the execute stage
// ALU commands, operand and write-back selects, exception codes,
// the decoded command and the exception report
`default_nettype none

package exu_isa_pkg;

    //----------------------------------------------------------------------
    // Integer ALU commands
    //----------------------------------------------------------------------
    // Seventeen commands, so the field needs five bits
    typedef enum logic [4:0] {
        ialu_cmd_none,
        ialu_cmd_add,
        ialu_cmd_sub,
        ialu_cmd_and,
        ialu_cmd_or,
        ialu_cmd_xor,
        ialu_cmd_sll,
        ialu_cmd_srl,
        ialu_cmd_sra,
        ialu_cmd_slt,       // Flag and 0/1 result
        ialu_cmd_sltu,      // Flag and 0/1 result
        ialu_cmd_eq,        // Branch compares, flag only
        ialu_cmd_ne,
        ialu_cmd_lt,
        ialu_cmd_ge,
        ialu_cmd_ltu,
        ialu_cmd_geu
    } ialu_cmd_e;

    typedef enum logic {ialu_op_reg_reg, ialu_op_reg_imm} ialu_op_e;
    typedef enum logic {sum2_op_pc_imm, sum2_op_reg_imm} sum2_op_e;

    typedef enum logic [2:0] {
        rd_wb_none,
        rd_wb_ialu,
        rd_wb_sum2,         // Address adder, auipc and friends
        rd_wb_imm,          // lui
        rd_wb_inc_pc        // Link address of jal/jalr
    } rd_wb_sel_e;

    typedef enum logic [3:0] {
        exc_code_instr_misalign    = 4'd0,
        exc_code_instr_access_fault = 4'd1,
        exc_code_illegal_instr     = 4'd2,
        exc_code_ecall_m           = 4'd11
    } exc_code_e;

    //----------------------------------------------------------------------
    // Decoded command from the decode stage
    //----------------------------------------------------------------------
    typedef struct packed {
        ialu_op_e                ialu_op;
        ialu_cmd_e               ialu_cmd;
        sum2_op_e                sum2_op;
        rd_wb_sel_e              rd_wb_sel;
        logic                    jump_req;
        logic                    branch_req;
        logic                    exc_req;      // Exception flagged by decoder
        exc_code_e               exc_code;
        exu_cfg_pkg::rf_addr_t   rs1_addr;
        exu_cfg_pkg::rf_addr_t   rs2_addr;
        exu_cfg_pkg::rf_addr_t   rd_addr;
        exu_cfg_pkg::xlen_t      imm;          // Raw instruction when exc_req
    } exu_cmd_t;

    typedef struct packed {
        logic                    exc_req;
        exc_code_e               exc_code;
        exu_cfg_pkg::xlen_t      trap_val;
    } exc_report_t;

endpackage : exu_isa_pkg

`default_nettype wire

// File: design/exu_cfg_pkg.sv
// Core configuration for the execute stage
// Data-path widths, word types and default PC vectors
`default_nettype none

package exu_cfg_pkg;

    localparam int unsigned xlen          = 32;   // Integer register width
    localparam int unsigned rf_addr_width = 5;    // 32 architectural registers

    typedef logic [xlen-1:0]          xlen_t;
    typedef logic [rf_addr_width-1:0] rf_addr_t;

    localparam xlen_t default_rst_vector  = 32'h0000_0200;  // First fetch after reset
    localparam xlen_t default_trap_vector = 32'h0000_0100;  // Fixed exception entry

    // Jump targets ignore bit 0 of the computed address
    localparam xlen_t jump_mask = 32'hFFFF_FFFE;

endpackage : exu_cfg_pkg

`default_nettype wire
